//--- build.f
hdl/avl_bus_pkg.sv
hdl/avl_arb_pkg.sv
hdl/avl_bus_n21_arb.sv
hdl/avl_cmd_mux.sv
hdl/fifo_sync.sv
hdl/fifo_sync_bypass.sv
hdl/avl_bus_n21.sv
test/avl_slave_model.sv
test/tb_avl_bus_n21.sv

//--- hdl/avl_arb_pkg.sv
package avl_arb_pkg;

    // how the arbiter picks the next master
    typedef enum logic [1:0] {
        ARB_FIXED       = 2'd0,   // lowest index wins
        ARB_ROUND_ROBIN = 2'd1    // search starts after the last grant
    } arb_method_e;

    // grant lock while a write burst is open
    typedef enum logic {
        ARB_IDLE  = 1'b0,
        ARB_BURST = 1'b1
    } arb_state_e;

endpackage

//--- hdl/avl_bus_n21.sv
`timescale 1ns/100ps

module avl_bus_n21 #(
    parameter int                       MASTER_NUM      = 4,   // at least 2
    parameter avl_arb_pkg::arb_method_e ARB_METHOD      = avl_arb_pkg::ARB_FIXED,
    parameter int                       SEL_FIFO_DEPTH  = 8,
    parameter int                       RESP_FIFO_DEPTH = 0
) (
    input  logic                                            clk,
    input  logic                                            arst_n,
    // master side
    input  logic [MASTER_NUM-1:0][avl_bus_pkg::ADDR_W-1:0]  m_address,
    input  logic [MASTER_NUM-1:0][avl_bus_pkg::BE_W-1:0]    m_byte_en,
    input  logic [MASTER_NUM-1:0]                           m_read,
    input  logic [MASTER_NUM-1:0]                           m_write,
    input  logic [MASTER_NUM-1:0][avl_bus_pkg::DATA_W-1:0]  m_write_data,
    input  logic [MASTER_NUM-1:0]                           m_begin_burst_transfer,
    input  logic [MASTER_NUM-1:0][avl_bus_pkg::BURST_W-1:0] m_burst_count,
    input  logic [MASTER_NUM-1:0]                           m_resp_ready,
    output logic [MASTER_NUM-1:0]                           m_request_ready,
    output logic [avl_bus_pkg::DATA_W-1:0]                  m_read_data,
    output logic [MASTER_NUM-1:0]                           m_read_data_valid,
    // slave side
    output logic [avl_bus_pkg::ADDR_W-1:0]                  s_address,
    output logic [avl_bus_pkg::BE_W-1:0]                    s_byte_en,
    output logic                                            s_read,
    output logic                                            s_write,
    output logic [avl_bus_pkg::DATA_W-1:0]                  s_write_data,
    output logic                                            s_begin_burst_transfer,
    output logic [avl_bus_pkg::BURST_W-1:0]                 s_burst_count,
    output logic                                            s_resp_ready,
    input  logic                                            s_request_ready,
    input  logic [avl_bus_pkg::DATA_W-1:0]                  s_read_data,
    input  logic                                            s_read_data_valid
);
    import avl_bus_pkg::*;

    localparam int SEL_W = $clog2(MASTER_NUM);

    logic [MASTER_NUM-1:0] request;
    logic [SEL_W-1:0]      sel;
    avl_op_e               op;
    logic                  cmd_accept;
    logic                  sel_push;
    logic                  sel_pop;
    logic                  sel_full;
    logic                  sel_empty;
    logic [SEL_W-1:0]      sel_head;    // master owed the oldest read
    logic                  resp_push;
    logic                  resp_full;
    logic                  resp_empty;
    logic                  resp_avail;
    logic                  head_valid;
    logic [DATA_W-1:0]     resp_data;

    // ==========================================================
    // command side
    // ==========================================================
    assign request    = m_read | m_write;
    assign cmd_accept = s_request_ready && (s_read || s_write);
    assign sel_push   = s_request_ready && s_read;   // remember who asked

    for (genvar i = 0; i < MASTER_NUM; i++) begin : g_master
        assign m_request_ready[i]   = (sel == SEL_W'(i)) && s_request_ready && !sel_full;
        assign m_read_data_valid[i] = head_valid && (sel_head == SEL_W'(i));
    end

    // ==========================================================
    // response side
    // ==========================================================
    // a depth 0 FIFO never holds data, so the slave beat itself is the response
    assign resp_avail   = (RESP_FIFO_DEPTH == 0) ? s_read_data_valid : !resp_empty;
    assign head_valid   = !sel_empty && resp_avail;
    assign sel_pop      = head_valid && m_resp_ready[sel_head];
    assign s_resp_ready = !resp_full;
    assign resp_push    = s_read_data_valid && s_resp_ready;
    assign m_read_data  = resp_data;

    avl_bus_n21_arb #(
        .MASTER_NUM (MASTER_NUM),
        .ARB_METHOD (ARB_METHOD)
    ) avl_bus_n21_arb_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .request         (request),
        .cmd_accept      (cmd_accept),
        .cmd_write       (op == OP_WRITE),
        .cmd_begin_burst (s_begin_burst_transfer),
        .cmd_burst_count (s_burst_count),
        .sel             (sel)
    );

    avl_cmd_mux #(
        .MASTER_NUM (MASTER_NUM)
    ) avl_cmd_mux_i (
        .sel                    (sel),
        .m_address              (m_address),
        .m_byte_en              (m_byte_en),
        .m_read                 (m_read),
        .m_write                (m_write),
        .m_write_data           (m_write_data),
        .m_begin_burst_transfer (m_begin_burst_transfer),
        .m_burst_count          (m_burst_count),
        .sel_full               (sel_full),
        .s_address              (s_address),
        .s_byte_en              (s_byte_en),
        .s_read                 (s_read),
        .s_write                (s_write),
        .s_write_data           (s_write_data),
        .s_begin_burst_transfer (s_begin_burst_transfer),
        .s_burst_count          (s_burst_count),
        .op                     (op)
    );

    fifo_sync #(
        .DEPTH (SEL_FIFO_DEPTH),
        .WIDTH (SEL_W)
    ) sel_fifo_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .write      (sel_push),
        .read       (sel_pop),
        .write_data (sel),
        .read_data  (sel_head),
        .full       (sel_full),
        .empty      (sel_empty)
    );

    fifo_sync_bypass #(
        .DEPTH (RESP_FIFO_DEPTH),
        .WIDTH (DATA_W)
    ) resp_fifo_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .write      (resp_push),
        .read       (sel_pop),     // data leaves together with its id
        .write_data (s_read_data),
        .read_data  (resp_data),
        .full       (resp_full),
        .empty      (resp_empty)
    );

endmodule

//--- hdl/avl_bus_n21_arb.sv
`timescale 1ns/100ps

module avl_bus_n21_arb #(
    parameter int                       MASTER_NUM = 4,
    parameter avl_arb_pkg::arb_method_e ARB_METHOD = avl_arb_pkg::ARB_FIXED
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [MASTER_NUM-1:0]           request,
    input  logic                            cmd_accept,      // command taken by the slave
    input  logic                            cmd_write,
    input  logic                            cmd_begin_burst,
    input  logic [avl_bus_pkg::BURST_W-1:0] cmd_burst_count,
    output logic [$clog2(MASTER_NUM)-1:0]   sel
);
    import avl_bus_pkg::*;
    import avl_arb_pkg::*;

    localparam int SEL_W = $clog2(MASTER_NUM);

    arb_state_e         state;
    logic [BURST_W-1:0] burst_left;   // beats still to come after the current one
    logic [SEL_W-1:0]   next_sel;
    logic               wr_beat;
    logic               burst_start;
    logic               burst_end;
    logic               rearb;

    // ==========================================================
    // burst tracking
    // ==========================================================
    assign wr_beat     = cmd_accept && cmd_write;
    assign burst_start = (state == ARB_IDLE) && wr_beat && cmd_begin_burst &&
                         (cmd_burst_count > BURST_W'(1));
    assign burst_end   = (state == ARB_BURST) && wr_beat && (burst_left == BURST_W'(1));

    // re-arbitrate once the granted command is done or the grant has gone idle
    assign rearb = burst_end ||
                   ((state == ARB_IDLE) && !burst_start && (!request[sel] || cmd_accept));

    // ==========================================================
    // next grant
    // ==========================================================
    always_comb begin
        int   idx;
        logic found;
        next_sel = sel;
        found    = 1'b0;
        idx      = 0;
        if (ARB_METHOD == ARB_FIXED) begin
            // scan downwards so the lowest requester is left in next_sel
            for (int i = MASTER_NUM - 1; i >= 0; i--) begin
                if (request[i]) begin
                    next_sel = SEL_W'(i);
                end
            end
        end else begin
            for (int k = 1; k <= MASTER_NUM; k++) begin
                idx = (int'(sel) + k) % MASTER_NUM;   // current grant is checked last
                if (!found && request[idx]) begin
                    next_sel = SEL_W'(idx);
                    found    = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ARB_IDLE;
            sel        <= '0;
            burst_left <= '0;
        end else begin
            if (rearb) begin
                sel <= next_sel;
            end
            case (state)
                ARB_IDLE: begin
                    if (burst_start) begin
                        state      <= ARB_BURST;
                        burst_left <= cmd_burst_count - 1'b1;
                    end
                end
                ARB_BURST: begin
                    if (burst_end) begin
                        state <= ARB_IDLE;
                    end else if (wr_beat) begin
                        burst_left <= burst_left - 1'b1;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // grant frozen for the whole burst including its entry cycle
    a_burst_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ARB_BURST) |-> $stable(sel));

    a_sel_range: assert property (@(posedge clk) disable iff (!arst_n)
        int'(sel) < MASTER_NUM);

endmodule

//--- hdl/avl_bus_pkg.sv
package avl_bus_pkg;

    // ==========================================================
    // bus field widths
    // ==========================================================
    localparam int ADDR_W  = 32;   // word address
    localparam int DATA_W  = 32;
    localparam int BE_W    = 4;    // one enable per byte of DATA_W
    localparam int BURST_W = 8;    // beats per write burst

    // ==========================================================
    // bus operation of the granted master
    // ==========================================================
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,   // single beat read
        OP_WRITE = 2'd2    // single write or one beat of a burst
    } avl_op_e;

endpackage

//--- hdl/avl_cmd_mux.sv
`timescale 1ns/100ps

module avl_cmd_mux #(
    parameter int MASTER_NUM = 4
) (
    input  logic [$clog2(MASTER_NUM)-1:0]                   sel,
    input  logic [MASTER_NUM-1:0][avl_bus_pkg::ADDR_W-1:0]  m_address,
    input  logic [MASTER_NUM-1:0][avl_bus_pkg::BE_W-1:0]    m_byte_en,
    input  logic [MASTER_NUM-1:0]                           m_read,
    input  logic [MASTER_NUM-1:0]                           m_write,
    input  logic [MASTER_NUM-1:0][avl_bus_pkg::DATA_W-1:0]  m_write_data,
    input  logic [MASTER_NUM-1:0]                           m_begin_burst_transfer,
    input  logic [MASTER_NUM-1:0][avl_bus_pkg::BURST_W-1:0] m_burst_count,
    input  logic                                            sel_full,
    output logic [avl_bus_pkg::ADDR_W-1:0]                  s_address,
    output logic [avl_bus_pkg::BE_W-1:0]                    s_byte_en,
    output logic                                            s_read,
    output logic                                            s_write,
    output logic [avl_bus_pkg::DATA_W-1:0]                  s_write_data,
    output logic                                            s_begin_burst_transfer,
    output logic [avl_bus_pkg::BURST_W-1:0]                 s_burst_count,
    output avl_bus_pkg::avl_op_e                            op
);
    import avl_bus_pkg::*;

    logic rd;
    logic wr;

    assign rd = m_read[sel];
    assign wr = m_write[sel];

    // payload fields follow the grant directly
    assign s_address     = m_address[sel];
    assign s_byte_en     = m_byte_en[sel];
    assign s_write_data  = m_write_data[sel];
    assign s_burst_count = m_burst_count[sel];

    // no new command while the select FIFO has no room for its id
    assign s_read                 = rd && !sel_full;
    assign s_write                = wr && !sel_full;
    assign s_begin_burst_transfer = m_begin_burst_transfer[sel] && !sel_full;

    always_comb begin
        if (wr) begin
            op = OP_WRITE;
        end else if (rd) begin
            op = OP_READ;
        end else begin
            op = OP_IDLE;
        end
    end

    a_rd_wr_excl: assert final ((rd & wr) !== 1'b1)
        else $error("granted master %0d drives read and write together", sel);

endmodule

//--- hdl/fifo_sync.sv
`timescale 1ns/100ps

module fifo_sync #(
    parameter int DEPTH = 8,   // power of two
    parameter int WIDTH = 2
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             write,
    input  logic             read,
    input  logic [WIDTH-1:0] write_data,
    output logic [WIDTH-1:0] read_data,
    output logic             full,
    output logic             empty
);
    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;   // wraps naturally at DEPTH
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_write;
    logic             do_read;

    assign do_write  = write && !full;
    assign do_read   = read && !empty;
    assign full      = (count == (PTR_W+1)'(DEPTH));
    assign empty     = (count == '0);
    assign read_data = mem[rd_ptr];   // head word shown ahead of the pop

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= write_data;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        write |-> !full);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        read |-> !empty);

endmodule

//--- hdl/fifo_sync_bypass.sv
`timescale 1ns/100ps

module fifo_sync_bypass #(
    parameter int DEPTH = 0,   // 0, 2, 4, 8 or 16
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             write,
    input  logic             read,
    input  logic [WIDTH-1:0] write_data,
    output logic [WIDTH-1:0] read_data,
    output logic             full,
    output logic             empty
);

    generate
        if (DEPTH == 0) begin : g_bypass
            // ==========================================================
            // pass-through
            // ==========================================================
            assign full      = !read;        // room only while the consumer takes the word
            assign empty     = 1'b1;
            assign read_data = write_data;
        end else begin : g_fifo
            // ==========================================================
            // registered FIFO
            // ==========================================================
            localparam int PTR_W = $clog2(DEPTH);

            logic [WIDTH-1:0] mem [DEPTH];
            logic [PTR_W:0]   wr_ptr;   // msb is the lap bit
            logic [PTR_W:0]   rd_ptr;

            assign empty = (wr_ptr == rd_ptr);
            assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                           (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
            assign read_data = mem[rd_ptr[PTR_W-1:0]];

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    wr_ptr <= '0;
                    rd_ptr <= '0;
                end else begin
                    if (write && !full) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                    if (read && !empty) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (write && !full) begin
                    mem[wr_ptr[PTR_W-1:0]] <= write_data;
                end
            end

            // the slave must hold its beat while s_resp_ready is low
            a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
                write |-> !full);
        end
    endgenerate

endmodule

//--- test/avl_slave_model.sv
`timescale 1ns/100ps

module avl_slave_model (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [avl_bus_pkg::ADDR_W-1:0] s_address,
    input  logic [avl_bus_pkg::BE_W-1:0]   s_byte_en,
    input  logic                         s_read,
    input  logic                         s_write,
    input  logic [avl_bus_pkg::DATA_W-1:0] s_write_data,
    input  logic                         s_resp_ready,
    output logic                         s_request_ready,
    output logic [avl_bus_pkg::DATA_W-1:0] s_read_data,
    output logic                         s_read_data_valid
);
    import avl_bus_pkg::*;

    logic [DATA_W-1:0] mem [int unsigned];
    logic [DATA_W-1:0] rd_q [$];     // read data waiting for its latency
    int                due_q [$];
    int                cyc = 0;
    logic [DATA_W-1:0] word;

    // unwritten words read back as the inverted address
    function automatic logic [DATA_W-1:0] peek(input logic [ADDR_W-1:0] a);
        return mem.exists(a) ? mem[a] : ~a;
    endfunction

    initial begin
        s_request_ready   = 1'b0;
        s_read_data       = '0;
        s_read_data_valid = 1'b0;
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cyc++;
            if (s_read_data_valid && s_resp_ready) begin
                void'(rd_q.pop_front());
                void'(due_q.pop_front());
            end
            if (s_request_ready && s_write) begin
                word = peek(s_address);
                for (int b = 0; b < BE_W; b++) begin
                    if (s_byte_en[b]) word[8*b +: 8] = s_write_data[8*b +: 8];
                end
                mem[s_address] = word;
            end
            if (s_request_ready && s_read) begin
                rd_q.push_back(peek(s_address));
                due_q.push_back(cyc + 2);   // fixed two-cycle latency
            end
        end
    end

    // random stalls on the command side, held response beats on the data side
    always @(negedge clk) begin
        s_request_ready   = arst_n && ($urandom_range(3) != 0);
        s_read_data_valid = (rd_q.size() != 0) && (due_q[0] <= cyc);
        s_read_data       = (rd_q.size() != 0) ? rd_q[0] : '0;
    end

endmodule

//--- test/tb_avl_bus_n21.sv
`timescale 1ns/100ps

module tb_avl_bus_n21;
    import avl_bus_pkg::*;
    import avl_arb_pkg::*;

    localparam int MN         = 4;
    localparam int SEL_DEPTH  = 8;
    localparam int RESP_DEPTH = 2;
    localparam int TMO        = 2000;   // cycles per wait

    logic clk;
    logic arst_n;
    logic [MN-1:0][ADDR_W-1:0]  m_address;
    logic [MN-1:0][BE_W-1:0]    m_byte_en;
    logic [MN-1:0]              m_read;
    logic [MN-1:0]              m_write;
    logic [MN-1:0][DATA_W-1:0]  m_write_data;
    logic [MN-1:0]              m_begin_burst_transfer;
    logic [MN-1:0][BURST_W-1:0] m_burst_count;
    logic [MN-1:0]              m_resp_ready;
    logic [MN-1:0]              m_request_ready;
    logic [DATA_W-1:0]          m_read_data;
    logic [MN-1:0]              m_read_data_valid;
    logic [ADDR_W-1:0]          s_address;
    logic [BE_W-1:0]            s_byte_en;
    logic                       s_read;
    logic                       s_write;
    logic [DATA_W-1:0]          s_write_data;
    logic                       s_begin_burst_transfer;
    logic [BURST_W-1:0]         s_burst_count;
    logic                       s_resp_ready;
    logic                       s_request_ready;
    logic [DATA_W-1:0]          s_read_data;
    logic                       s_read_data_valid;

    // ==========================================================
    // scoreboard state
    // ==========================================================
    logic [DATA_W-1:0] shadow [int unsigned];
    logic [DATA_W-1:0] exp_q [MN][$];     // expected read data per master
    logic [DATA_W-1:0] exp_head [MN];
    int                ord_q [$];         // masters in read issue order
    int                ord_head = 0;
    int                ord_cnt = 0;
    int                outstanding = 0;   // reads accepted but not delivered
    int                resp_occ = 0;      // words held in the response FIFO
    int                wait_cnt [MN] = '{default: 0};
    logic              in_burst = 1'b0;
    int                burst_owner = 0;
    int                burst_left = 0;
    logic [ADDR_W-1:0] burst_addr = '0;
    logic              seen_req = 1'b0;
    logic              resp_hold = 1'b0;
    int                value_errors = 0;
    int                order_errors = 0;
    int                proto_errors = 0;
    int                timeouts = 0;
    int                accepted;
    logic              counted;
    int                t;

    avl_bus_n21 #(
        .MASTER_NUM      (MN),
        .ARB_METHOD      (ARB_ROUND_ROBIN),
        .SEL_FIFO_DEPTH  (SEL_DEPTH),
        .RESP_FIFO_DEPTH (RESP_DEPTH)
    ) avl_bus_n21_i (.*);

    avl_slave_model slave_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [DATA_W-1:0] word_at(input logic [ADDR_W-1:0] a);
        return shadow.exists(a) ? shadow[a] : ~a;
    endfunction

    function automatic logic [DATA_W-1:0] merge_be(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] d,
                                                    input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] w;
        w = old;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) w[8*b +: 8] = d[8*b +: 8];
        end
        return w;
    endfunction

    // ==========================================================
    // bus model that tracks what the bus should do next
    // ==========================================================
    always @(posedge clk) begin
        if (arst_n) begin
            accepted = -1;
            counted  = !in_burst;   // later burst beats are not new grants
            if (|(m_read | m_write)) seen_req = 1'b1;
            for (int i = 0; i < MN; i++) begin
                if (m_read_data_valid[i] && m_resp_ready[i]) begin
                    if (exp_q[i].size() != 0) void'(exp_q[i].pop_front());
                    if (ord_q.size() != 0) void'(ord_q.pop_front());
                    outstanding--;
                    resp_occ--;
                end
            end
            if (s_read_data_valid && s_resp_ready) resp_occ++;
            for (int i = 0; i < MN; i++) begin
                if (m_request_ready[i] && (m_read[i] || m_write[i])) begin
                    accepted = i;
                    if (m_write[i]) begin
                        shadow[m_address[i]] = merge_be(word_at(m_address[i]),
                                                        m_write_data[i], m_byte_en[i]);
                        if (in_burst) begin
                            burst_left--;
                            burst_addr++;
                            if (burst_left == 0) in_burst = 1'b0;
                        end else if (m_begin_burst_transfer[i] && m_burst_count[i] > 1) begin
                            in_burst    = 1'b1;
                            burst_owner = i;
                            burst_left  = m_burst_count[i] - 1;
                            burst_addr  = m_address[i] + 1;
                        end
                    end else begin
                        exp_q[i].push_back(word_at(m_address[i]));
                        ord_q.push_back(i);
                        outstanding++;
                    end
                end
            end
            for (int k = 0; k < MN; k++) begin
                if (!(m_read[k] || m_write[k]) || accepted == k) wait_cnt[k] = 0;
                else if (accepted >= 0 && counted) wait_cnt[k]++;
                exp_head[k] = (exp_q[k].size() != 0) ? exp_q[k][0] : '0;
            end
            ord_cnt  = ord_q.size();
            ord_head = (ord_cnt != 0) ? ord_q[0] : 0;
        end
    end

    // ==========================================================
    // checks
    // ==========================================================
    for (genvar g = 0; g < MN; g++) begin : g_chk
        a_readback: assert property (@(posedge clk) disable iff (!arst_n)
            (m_read_data_valid[g] && m_resp_ready[g]) |-> (m_read_data == exp_head[g]))
            else begin
                value_errors++;
                $display("** Error readback m%0d: expected %h, actual %h", g,
                         $sampled(exp_head[g]), $sampled(m_read_data));
            end
        a_route: assert property (@(posedge clk) disable iff (!arst_n)
            m_read_data_valid[g] |-> (ord_cnt != 0 && ord_head == g))
            else begin
                order_errors++;
                $display("** Error routing: expected m%0d, actual m%0d", $sampled(ord_head), g);
            end
        a_burst_fields: assert property (@(posedge clk) disable iff (!arst_n)
            (m_request_ready[g] && (m_read[g] || m_write[g])) |->
            (s_begin_burst_transfer == m_begin_burst_transfer[g] &&
             s_burst_count == m_burst_count[g]))
            else begin
                value_errors++;
                $display("** Error burst fields m%0d: expected %b/%0d, actual %b/%0d", g,
                         $sampled(m_begin_burst_transfer[g]), $sampled(m_burst_count[g]),
                         $sampled(s_begin_burst_transfer), $sampled(s_burst_count));
            end
        a_rr_fair: assert property (@(posedge clk) disable iff (!arst_n) wait_cnt[g] < MN)
            else begin
                proto_errors++;
                $display("master %0d waited for more than %0d other grants", g, MN - 1);
            end
    end

    a_burst_lock: assert property (@(posedge clk) disable iff (!arst_n)
        (in_burst && s_write && s_request_ready) |->
        (m_request_ready[burst_owner] && s_address == burst_addr))
        else begin
            value_errors++;
            $display("** Error burst lock: expected %h, actual %h",
                     $sampled(burst_addr), $sampled(s_address));
        end

    // the oldest read's master blocks every later response while it stalls
    a_resp_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (ord_cnt != 0 && !m_resp_ready[ord_head]) |-> !(|(m_read_data_valid & m_resp_ready)))
        else begin
            proto_errors++;
            $display("a response was delivered while the head master stalled");
        end

    a_resp_full: assert property (@(posedge clk) disable iff (!arst_n)
        (resp_occ == RESP_DEPTH) |-> !s_resp_ready)
        else begin
            proto_errors++;
            $display("s_resp_ready stayed high with the response FIFO full");
        end

    a_sel_full: assert property (@(posedge clk) disable iff (!arst_n)
        (outstanding == SEL_DEPTH) |-> !(s_request_ready && (s_read || s_write)))
        else begin
            proto_errors++;
            $display("a command was accepted with the select FIFO full");
        end

    a_reset_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        (!seen_req && !(|(m_read | m_write))) |->
        (m_read_data_valid == '0 && !s_read && !s_write))
        else begin
            proto_errors++;
            $display("bus was active after reset before any request");
        end

    // ==========================================================
    // stimulus
    // ==========================================================
    task automatic send_cmd(input int m, input logic rd, input logic [ADDR_W-1:0] a,
                            input logic [BE_W-1:0] be, input logic [DATA_W-1:0] d,
                            input logic bb, input logic [BURST_W-1:0] bc);
        int n;
        n = 0;
        @(negedge clk);
        m_read[m]                 = rd;
        m_write[m]                = !rd;
        m_address[m]              = a;
        m_byte_en[m]              = be;
        m_write_data[m]           = d;
        m_begin_burst_transfer[m] = bb;
        m_burst_count[m]          = bc;
        do begin
            @(posedge clk);
            n++;
        end while (!m_request_ready[m] && n < TMO);
        if (!m_request_ready[m]) begin
            timeouts++;
            $display("master %0d: command to %h was never accepted", m, a);
        end
    endtask

    task automatic run_master(input int m);
        logic [ADDR_W-1:0] base;
        base = m * 256;   // own address range per master
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 4; k++) begin
                send_cmd(m, 0, base + k, $urandom_range(15, 1), $urandom, 0, 1);
            end
            for (int k = 0; k < 4; k++) send_cmd(m, 0, base + 8 + k, 4'hf, $urandom, k == 0, 4);
            for (int k = 0; k < 4; k++) send_cmd(m, 1, base + k, 4'hf, '0, 0, 1);
            for (int k = 0; k < 4; k++) send_cmd(m, 1, base + 8 + k, 4'hf, '0, 0, 1);
        end
        @(negedge clk);
        m_read[m]                 = 1'b0;
        m_write[m]                = 1'b0;
        m_begin_burst_transfer[m] = 1'b0;
    endtask

    always @(negedge clk) begin
        for (int k = 0; k < MN; k++) m_resp_ready[k] = !resp_hold && ($urandom_range(3) != 0);
    end

    initial begin
        void'($urandom(94));
        arst_n = 1'b0;
        m_address = '0;
        m_byte_en = '0;
        m_read = '0;
        m_write = '0;
        m_write_data = '0;
        m_begin_burst_transfer = '0;
        m_burst_count = '0;
        m_resp_ready = '0;
        repeat (2) @(posedge clk);
        @(negedge clk) arst_n = 1'b1;
        repeat (3) @(negedge clk);
        fork
            run_master(0);
            run_master(1);
            run_master(2);
            run_master(3);
            begin
                repeat (60) @(negedge clk);
                resp_hold = 1'b1;   // let both FIFOs fill up
                repeat (30) @(negedge clk);
                resp_hold = 1'b0;
            end
        join
        t = 0;
        while (ord_cnt != 0 && t < TMO) begin
            @(posedge clk);
            t++;
        end
        if (ord_cnt != 0) begin
            timeouts++;
            $display("%0d read responses never arrived", ord_cnt);
        end
        repeat (5) @(posedge clk);
        $display("value errors %0d, order errors %0d, protocol errors %0d, timeouts %0d",
                 value_errors, order_errors, proto_errors, timeouts);
        if (value_errors + order_errors + proto_errors + timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
